// File: Makefile
VERILATOR ?= verilator
TOP       ?= debug_dma_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= all tests passed
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: design/dbg_ifs.sv
// checker-to-engine request and checker-to-responder result links; single request in flight
`timescale 1ns/1ps

// ------------------------------------------------------------
// dma request link
// ------------------------------------------------------------

// req_val is a one-cycle strobe, nothing more until done
// rd_data only valid in the done cycle
interface dma_req_if #(
	parameter int addr_w = dma_pkg::ADDR_W,
	parameter int data_w = dma_pkg::DATA_W
);
	logic               req_val;
	dma_pkg::dma_inst_t inst;
	logic [addr_w-1:0]  src_addr;
	logic [addr_w-1:0]  dest_addr;
	logic               done;
	logic [data_w-1:0]  rd_data;

	modport chk (output req_val, inst, src_addr, dest_addr, input done, rd_data);
	modport engine (input req_val, inst, src_addr, dest_addr, output done, rd_data);
endinterface

// ------------------------------------------------------------
// debug response link
// ------------------------------------------------------------

// resp_val pulses once per accepted request
// status, data and domain valid with resp_val
interface debug_resp_if #(
	parameter int data_w = dma_pkg::DATA_W
);
	logic                       resp_val;
	security_pkg::resp_status_t status;
	logic [data_w-1:0]          data;
	security_pkg::domain_t      domain;

	modport chk (output resp_val, status, data, domain);
	modport responder (input resp_val, status, data, domain);
endinterface

// File: design/debug_checker.sv
// domain compared once in the check cycle; debug_val is ignored until the response goes out
`timescale 1ns/1ps

module debug_checker #(
	parameter int addr_w = dma_pkg::ADDR_W,
	parameter int data_w = dma_pkg::DATA_W
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  debug_val,
	input  security_pkg::domain_t debug_domain,
	input  dma_pkg::dma_inst_t    debug_inst,
	input  dma_pkg::addr_t        debug_src_addr,
	input  dma_pkg::addr_t        debug_dest_addr,
	input  security_pkg::domain_t dma_domain,
	dma_req_if.chk                req,
	debug_resp_if.chk             resp
);

	// ------------------------------------------------------------
	// state machine
	// ------------------------------------------------------------

	typedef enum logic [2:0] {
		CK_IDLE,
		CK_CHECK,
		CK_REQUEST,
		CK_WAIT,
		CK_RESPOND
	} state_t;

	state_t state;
	state_t state_next;

	// latched request
	security_pkg::domain_t dom_q;
	dma_pkg::dma_inst_t    inst_q;
	logic [addr_w-1:0]     src_q;
	logic [addr_w-1:0]     dest_q;

	// check result and returned word
	logic                  denied_q;
	logic [data_w-1:0]     data_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= CK_IDLE;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			CK_IDLE: begin
				if (debug_val) begin
					state_next = CK_CHECK;
				end
			end
			// granted goes to the engine, denied skips to respond
			CK_CHECK: begin
				if (dom_q >= dma_domain) begin
					state_next = CK_REQUEST;
				end else begin
					state_next = CK_RESPOND;
				end
			end
			CK_REQUEST: state_next = CK_WAIT;
			CK_WAIT: begin
				if (req.done) begin
					state_next = CK_RESPOND;
				end
			end
			CK_RESPOND: state_next = CK_IDLE;
			default: state_next = CK_IDLE;
		endcase
	end

	// ------------------------------------------------------------
	// request and result registers
	// ------------------------------------------------------------

	always_ff @(posedge clk) begin
		// capture only from idle, later strobes are dropped
		if (state == CK_IDLE && debug_val) begin
			dom_q  <= debug_domain;
			inst_q <= debug_inst;
			src_q  <= debug_src_addr;
			dest_q <= debug_dest_addr;
		end
		// dma_domain may move later, keep the decision from here
		if (state == CK_CHECK) begin
			denied_q <= (dom_q < dma_domain);
		end
		if (state == CK_WAIT && req.done) begin
			data_q <= req.rd_data;
		end
	end

	// ------------------------------------------------------------
	// outputs
	// ------------------------------------------------------------

	assign req.req_val   = (state == CK_REQUEST);
	assign req.inst      = inst_q;
	assign req.src_addr  = src_q;
	assign req.dest_addr = dest_q;

	// data is stale on denied, responder zeroes it
	assign resp.resp_val = (state == CK_RESPOND);
	assign resp.status   = denied_q ? security_pkg::RESP_DENIED : security_pkg::RESP_OK;
	assign resp.data     = data_q;
	assign resp.domain   = dom_q;

endmodule

// File: design/debug_dma_top.sv
// mem_depth must not exceed 2**addr_w; host port and debug port run on the same clock
`timescale 1ns/1ps

module debug_dma_top #(
	parameter int addr_w    = dma_pkg::ADDR_W,
	parameter int data_w    = dma_pkg::DATA_W,
	parameter int mem_depth = 64
) (
	input  logic                  clk,
	input  logic                  reset,
	// host fill port
	input  logic                  host_we,
	input  dma_pkg::addr_t        host_addr,
	input  dma_pkg::data_t        host_wdata,
	// debug request
	input  logic                  debug_val,
	input  security_pkg::domain_t debug_domain,
	input  dma_pkg::dma_inst_t    debug_inst,
	input  dma_pkg::addr_t        debug_src_addr,
	input  dma_pkg::addr_t        debug_dest_addr,
	// current domain of the dma block, a level
	input  security_pkg::domain_t dma_domain,
	// debug response
	output logic                  debug_ack,
	output logic                  debug_denied,
	output dma_pkg::data_t        debug_data,
	output security_pkg::domain_t debug_resp_domain
);

	// ------------------------------------------------------------
	// internal links
	// ------------------------------------------------------------

	dma_req_if #(.addr_w(addr_w), .data_w(data_w)) req_bus ();
	debug_resp_if #(.data_w(data_w)) resp_bus ();
	mem_if #(.addr_w(addr_w), .data_w(data_w)) mem_bus ();

	// ------------------------------------------------------------
	// decode, execute, result
	// ------------------------------------------------------------

	debug_checker #(.addr_w(addr_w), .data_w(data_w)) u_checker (
		.clk             (clk),
		.reset           (reset),
		.debug_val       (debug_val),
		.debug_domain    (debug_domain),
		.debug_inst      (debug_inst),
		.debug_src_addr  (debug_src_addr),
		.debug_dest_addr (debug_dest_addr),
		.dma_domain      (dma_domain),
		.req             (req_bus.chk),
		.resp            (resp_bus.chk)
	);

	dma_engine #(.addr_w(addr_w), .data_w(data_w)) u_engine (
		.clk   (clk),
		.reset (reset),
		.req   (req_bus.engine),
		.mem   (mem_bus.engine)
	);

	scratch_mem #(.addr_w(addr_w), .data_w(data_w), .mem_depth(mem_depth)) u_mem (
		.clk        (clk),
		.mem        (mem_bus.memory),
		.host_we    (host_we),
		.host_addr  (host_addr),
		.host_wdata (host_wdata)
	);

	debug_responder #(.data_w(data_w)) u_responder (
		.clk               (clk),
		.reset             (reset),
		.resp              (resp_bus.responder),
		.debug_ack         (debug_ack),
		.debug_denied      (debug_denied),
		.debug_data        (debug_data),
		.debug_resp_domain (debug_resp_domain)
	);

endmodule

// File: design/debug_responder.sv
// outputs hold until the next response; debug_data forced to zero on a denied response
`timescale 1ns/1ps

module debug_responder #(
	parameter int data_w = dma_pkg::DATA_W
) (
	input  logic                  clk,
	input  logic                  reset,
	debug_resp_if.responder       resp,
	output logic                  debug_ack,
	output logic                  debug_denied,
	output dma_pkg::data_t        debug_data,
	output security_pkg::domain_t debug_resp_domain
);

	logic [data_w-1:0] data_q;

	// ------------------------------------------------------------
	// ack pulse
	// ------------------------------------------------------------

	// one cycle after resp_val, one cycle wide
	always_ff @(posedge clk) begin
		if (reset) begin
			debug_ack <= 1'b0;
		end else begin
			debug_ack <= resp.resp_val;
		end
	end

	// ------------------------------------------------------------
	// held result
	// ------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (resp.resp_val) begin
			debug_denied      <= (resp.status == security_pkg::RESP_DENIED);
			debug_resp_domain <= resp.domain;
			// nothing leaks out on a denied request
			if (resp.status == security_pkg::RESP_DENIED) begin
				data_q <= '0;
			end else begin
				data_q <= resp.data;
			end
		end
	end

	assign debug_data = data_q;

endmodule

// File: design/dma_engine.sv
// read done 2 cycles after req_val, copy done 3 cycles after; one operation at a time
`timescale 1ns/1ps

module dma_engine #(
	parameter int addr_w = dma_pkg::ADDR_W,
	parameter int data_w = dma_pkg::DATA_W
) (
	input logic       clk,
	input logic       reset,
	dma_req_if.engine req,
	mem_if.engine     mem
);

	// ------------------------------------------------------------
	// state machine
	// ------------------------------------------------------------

	// idle also issues the source read in the req_val cycle
	typedef enum logic [1:0] {
		EN_IDLE,
		EN_CAPTURE,
		EN_WRITE,
		EN_DONE
	} state_t;

	state_t state;
	state_t state_next;

	dma_pkg::dma_inst_t inst_q;
	logic [addr_w-1:0]  dest_q;

	// source word, returned in rd_data and written on copy
	logic [data_w-1:0]  data_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= EN_IDLE;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			EN_IDLE: begin
				if (req.req_val) begin
					state_next = EN_CAPTURE;
				end
			end
			EN_CAPTURE: begin
				if (inst_q == dma_pkg::INST_COPY) begin
					state_next = EN_WRITE;
				end else begin
					state_next = EN_DONE;
				end
			end
			EN_WRITE: state_next = EN_DONE;
			EN_DONE: state_next = EN_IDLE;
			default: state_next = EN_IDLE;
		endcase
	end

	// ------------------------------------------------------------
	// datapath
	// ------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (state == EN_IDLE && req.req_val) begin
			inst_q <= req.inst;
			dest_q <= req.dest_addr;
		end
		// read data lands one cycle after the read enable
		if (state == EN_CAPTURE) begin
			data_q <= mem.rdata;
		end
	end

	// source read straight from the request fields, no extra cycle
	assign mem.en    = (state == EN_IDLE && req.req_val) || (state == EN_WRITE);
	assign mem.we    = (state == EN_WRITE);
	assign mem.addr  = (state == EN_WRITE) ? dest_q : req.src_addr;
	assign mem.wdata = data_q;

	assign req.done    = (state == EN_DONE);
	assign req.rd_data = data_q;

endmodule

// File: design/dma_pkg.sv
// address, data and instruction types; typedef widths follow the package defaults only
package dma_pkg;

	// ------------------------------------------------------------
	// default widths
	// ------------------------------------------------------------

	// word address, 64 words by default
	localparam int ADDR_W = 6;

	// data word
	localparam int DATA_W = 32;

	// ------------------------------------------------------------
	// types
	// ------------------------------------------------------------

	// word address into the scratch memory
	typedef logic [ADDR_W-1:0] addr_t;

	// one data word
	typedef logic [DATA_W-1:0] data_t;

	// read returns the source word
	// copy writes the source word to the destination and returns it
	typedef enum logic {
		INST_READ = 1'b0,
		INST_COPY = 1'b1
	} dma_inst_t;

endpackage

// File: design/mem_if.sv
// engine port of the scratch memory; rdata arrives one cycle after a read enable
`timescale 1ns/1ps

// engine drives the command, memory returns the read word
// write when en and we are both high
// read when en is high and we is low
interface mem_if #(
	parameter int addr_w = dma_pkg::ADDR_W,
	parameter int data_w = dma_pkg::DATA_W
);
	logic              en;
	logic              we;
	logic [addr_w-1:0] addr;
	logic [data_w-1:0] wdata;

	// registered in the memory
	logic [data_w-1:0] rdata;

	modport engine (output en, we, addr, wdata, input rdata);
	modport memory (input en, we, addr, wdata, output rdata);
endinterface

// File: design/scratch_mem.sv
// no reset on contents; addresses at or above mem_depth are not written and read as zero
`timescale 1ns/1ps

module scratch_mem #(
	parameter int addr_w    = dma_pkg::ADDR_W,
	parameter int data_w    = dma_pkg::DATA_W,
	parameter int mem_depth = 64
) (
	input logic           clk,
	mem_if.memory         mem,
	input logic           host_we,
	input dma_pkg::addr_t host_addr,
	input dma_pkg::data_t host_wdata
);

	logic [data_w-1:0] ram [mem_depth];

	// range checks
	logic host_hit;
	logic eng_hit;

	assign host_hit = (host_addr < mem_depth);
	assign eng_hit  = (mem.addr < mem_depth);

	// ------------------------------------------------------------
	// write ports and synchronous read
	// ------------------------------------------------------------

	always_ff @(posedge clk) begin
		// system side fill
		if (host_we && host_hit) begin
			ram[host_addr] <= host_wdata;
		end
		// engine write comes last so it wins on the same address
		if (mem.en && mem.we && eng_hit) begin
			ram[mem.addr] <= mem.wdata;
		end
		if (mem.en && !mem.we) begin
			mem.rdata <= eng_hit ? ram[mem.addr] : '0;
		end
	end

endmodule

// File: design/security_pkg.sv
// security domain and response status types; domain is 1 bit, so only normal and secure exist
package security_pkg;

	// ------------------------------------------------------------
	// security domain
	// ------------------------------------------------------------

	// 0 is normal, 1 is secure
	// a requester is granted when its domain is at least the dma domain
	typedef logic domain_t;

	// ------------------------------------------------------------
	// response status
	// ------------------------------------------------------------

	// carried from checker to responder with every response
	// denied responses carry no data and touch no memory
	typedef enum logic {
		RESP_OK     = 1'b0,
		RESP_DENIED = 1'b1
	} resp_status_t;

endpackage

// File: filelist.f
design/security_pkg.sv
design/dma_pkg.sv
design/dbg_ifs.sv
design/mem_if.sv
design/debug_checker.sv
design/dma_engine.sv
design/scratch_mem.sv
design/debug_responder.sv
design/debug_dma_top.sv
sim/debug_dma_assert.sv
sim/debug_dma_tb.sv

// File: sim/debug_dma_assert.sv
// bound into debug_dma_top; watches the request and memory links through the top's interfaces
`timescale 1ns/1ps

module debug_dma_assert (
	input logic               clk,
	input logic               reset,
	input logic               debug_ack,
	input logic               req_val,
	input dma_pkg::dma_inst_t req_inst,
	input logic               req_done,
	input logic               mem_en,
	input logic               mem_we
);

	// number of property failures so far
	int fail_count = 0;

	// ------------------------------------------------------------
	// granted copy tracking
	// ------------------------------------------------------------

	// req_val only fires on a grant, so this marks a granted copy
	logic copy_flight;

	always_ff @(posedge clk) begin
		if (reset) begin
			copy_flight <= 1'b0;
		end else if (req_val && req_inst == dma_pkg::INST_COPY) begin
			copy_flight <= 1'b1;
		end else if (req_done) begin
			copy_flight <= 1'b0;
		end
	end

	// ------------------------------------------------------------
	// properties
	// ------------------------------------------------------------

	a_ack_single: assert property (@(posedge clk) disable iff (reset) debug_ack |=> !debug_ack)
		else begin
			fail_count++;
			$error("debug_ack high for two cycles in a row");
		end

	a_write_copy: assert property (@(posedge clk) disable iff (reset)
		(mem_en && mem_we) |-> copy_flight)
		else begin
			fail_count++;
			$error("memory write without a granted copy in flight");
		end

	a_ack_reset: assert property (@(posedge clk) reset |=> !debug_ack)
		else begin
			fail_count++;
			$error("debug_ack not low after reset");
		end

endmodule

bind debug_dma_top debug_dma_assert u_assert (
	.clk       (clk),
	.reset     (reset),
	.debug_ack (debug_ack),
	.req_val   (req_bus.req_val),
	.req_inst  (req_bus.inst),
	.req_done  (req_bus.done),
	.mem_en    (mem_bus.en),
	.mem_we    (mem_bus.we)
);

// File: sim/debug_dma_tb.sv
// memory is filled by the host before any debug access; one debug request in flight at a time
`timescale 1ns/1ps

module debug_dma_tb;

	localparam int MEM_DEPTH   = 64;
	localparam int ACK_TIMEOUT = 32;
	localparam int RAND_OPS    = 80;

	logic                  clk;
	logic                  reset;
	logic                  host_we;
	dma_pkg::addr_t        host_addr;
	dma_pkg::data_t        host_wdata;
	logic                  debug_val;
	security_pkg::domain_t debug_domain;
	dma_pkg::dma_inst_t    debug_inst;
	dma_pkg::addr_t        debug_src_addr;
	dma_pkg::addr_t        debug_dest_addr;
	security_pkg::domain_t dma_domain;
	logic                  debug_ack;
	logic                  debug_denied;
	dma_pkg::data_t        debug_data;
	security_pkg::domain_t debug_resp_domain;

	// reference copy of the scratch memory
	dma_pkg::data_t ref_mem [MEM_DEPTH];
	int             err_count;
	int             check_count;
	integer         seed;
	// set when an ack never arrives
	logic           hung;

	debug_dma_top #(
		.addr_w    (dma_pkg::ADDR_W),
		.data_w    (dma_pkg::DATA_W),
		.mem_depth (MEM_DEPTH)
	) DUT (
		.clk               (clk),
		.reset             (reset),
		.host_we           (host_we),
		.host_addr         (host_addr),
		.host_wdata        (host_wdata),
		.debug_val         (debug_val),
		.debug_domain      (debug_domain),
		.debug_inst        (debug_inst),
		.debug_src_addr    (debug_src_addr),
		.debug_dest_addr   (debug_dest_addr),
		.dma_domain        (dma_domain),
		.debug_ack         (debug_ack),
		.debug_denied      (debug_denied),
		.debug_data        (debug_data),
		.debug_resp_domain (debug_resp_domain)
	);

	// 8 ns period
	always #4 clk = ~clk;

	// ------------------------------------------------------------
	// compare and wait helpers
	// ------------------------------------------------------------

	task automatic check_data(input string name, input dma_pkg::data_t got,
			input dma_pkg::data_t exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_domain(input string name, input security_pkg::domain_t got,
			input security_pkg::domain_t exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("FAIL t=%0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_status(input string name, input security_pkg::resp_status_t got,
			input security_pkg::resp_status_t exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("FAIL t=%0t %s got %s expected %s", $time, name, got.name(), exp.name());
		end
	endtask

	// assertion failures of the bound checker count as errors too
	task automatic finish_run();
		int total;
		total = err_count + DUT.u_assert.fail_count;
		$display("checks %0d, errors %0d, assertion failures %0d", check_count, err_count,
			DUT.u_assert.fail_count);
		if (total == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	endtask

	// outputs sampled on the falling edge, away from the register updates
	task automatic wait_ack();
		int  n;
		logic seen;
		n    = 0;
		seen = 1'b0;
		while (!seen && n < ACK_TIMEOUT) begin
			@(negedge clk);
			seen = debug_ack;
			n++;
		end
		if (!seen) begin
			$display("no debug_ack within %0d cycles of the request", ACK_TIMEOUT);
			err_count++;
			hung = 1'b1;
		end
	endtask

	// ------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------

	task automatic host_write(input dma_pkg::addr_t a, input dma_pkg::data_t d);
		@(posedge clk);
		host_we    <= 1'b1;
		host_addr  <= a;
		host_wdata <= d;
		@(posedge clk);
		host_we <= 1'b0;
		ref_mem[a] = d;
	endtask

	task automatic set_dma_domain(input security_pkg::domain_t d);
		@(posedge clk);
		dma_domain <= d;
	endtask

	// one request, expected result from the grant rule and the model
	task automatic run_request(input security_pkg::domain_t dom, input dma_pkg::dma_inst_t inst,
			input dma_pkg::addr_t src, input dma_pkg::addr_t dest);
		logic granted;
		@(posedge clk);
		debug_val       <= 1'b1;
		debug_domain    <= dom;
		debug_inst      <= inst;
		debug_src_addr  <= src;
		debug_dest_addr <= dest;
		@(posedge clk);
		debug_val <= 1'b0;
		wait_ack();
		if (!hung) begin
			// dma_domain is held for the whole request
			granted = (dom >= dma_domain);
			check_data("debug_data", debug_data, granted ? ref_mem[src] : '0);
			check_status("debug_denied", security_pkg::resp_status_t'(debug_denied),
				granted ? security_pkg::RESP_OK : security_pkg::RESP_DENIED);
			check_domain("debug_resp_domain", debug_resp_domain, dom);
			if (granted && inst == dma_pkg::INST_COPY) begin
				ref_mem[dest] = ref_mem[src];
			end
		end
	endtask

	// ------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------

	task automatic test_granted_read();
		host_write(7, 32'h1234_abcd);
		set_dma_domain(1'b0);
		run_request(1'b0, dma_pkg::INST_READ, 7, 0);
		run_request(1'b1, dma_pkg::INST_READ, 62, 0);
		set_dma_domain(1'b1);
		run_request(1'b1, dma_pkg::INST_READ, 7, 0);
	endtask

	// denied copy must leave address 40 alone
	task automatic test_denied();
		set_dma_domain(1'b1);
		run_request(1'b0, dma_pkg::INST_READ, 12, 0);
		run_request(1'b0, dma_pkg::INST_COPY, 3, 40);
		run_request(1'b1, dma_pkg::INST_READ, 40, 0);
	endtask

	task automatic test_copy();
		set_dma_domain(1'b0);
		run_request(1'b0, dma_pkg::INST_COPY, 5, 20);
		run_request(1'b0, dma_pkg::INST_READ, 20, 0);
		set_dma_domain(1'b1);
		run_request(1'b1, dma_pkg::INST_COPY, 33, 34);
		run_request(1'b1, dma_pkg::INST_READ, 34, 0);
	endtask

	// all four requester and dma domain pairs
	task automatic test_resp_domain();
		for (int d = 0; d < 2; d++) begin
			for (int r = 0; r < 2; r++) begin
				set_dma_domain(security_pkg::domain_t'(d));
				run_request(security_pkg::domain_t'(r), dma_pkg::INST_READ, 9, 0);
			end
		end
	endtask

	task automatic test_random();
		int r;
		for (int i = 0; i < RAND_OPS; i++) begin
			r = $random(seed);
			if (r[1:0] == 2'd0) begin
				host_write(r[8 +: dma_pkg::ADDR_W], $random(seed));
			end else begin
				set_dma_domain(r[2]);
				run_request(r[3], dma_pkg::dma_inst_t'(r[4]), r[8 +: dma_pkg::ADDR_W],
					r[16 +: dma_pkg::ADDR_W]);
			end
		end
	endtask

	// host fill, then every directed test
	task automatic run_tests();
		// pattern over the whole address
		for (int a = 0; a < MEM_DEPTH; a++) begin
			host_write(dma_pkg::addr_t'(a), 32'h1f3a_5c00 ^ (32'h0101_0101 * a) ^ (a << 26));
		end
		test_granted_read();
		test_denied();
		test_copy();
		test_resp_domain();
		test_random();
	endtask

	initial begin
		clk             = 1'b0;
		reset           = 1'b1;
		host_we         = 1'b0;
		host_addr       = '0;
		host_wdata      = '0;
		debug_val       = 1'b0;
		debug_domain    = 1'b0;
		debug_inst      = dma_pkg::INST_READ;
		debug_src_addr  = '0;
		debug_dest_addr = '0;
		dma_domain      = 1'b0;
		err_count       = 0;
		check_count     = 0;
		hung            = 1'b0;
		seed            = 32'hb2e1_d9dc;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		// a missing ack cuts the sequence short
		fork
			run_tests();
			wait (hung);
		join_any
		finish_run();
	end

endmodule
